/* Makefile */
# Verilator build and run for the SoC interconnect testbench
# override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= soc_tb
FILE_LIST ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILE_LIST)) include/soc_defs.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

# exit status of the binary is the result of the run
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* design/addr_decoder.sv */
// ----------------------------------------
// address decoder, routes the granted access to the CLINT or the RAM
// unmapped addresses get a local error response
// ----------------------------------------
`include "soc_defs.svh"

module addr_decoder (
  soc_bus_if.slave  s_bus,
  soc_bus_if.master clint_bus,
  soc_bus_if.master ram_bus,
  input  logic      sys_clk_i,
  input  logic      rst_n_i
);

  localparam logic [`SOC_ADDR_W-1:0] RAM_SIZE = `SOC_RAM_WORDS * `SOC_BE_W;

  logic [`SOC_ADDR_W-1:0]  clint_ofs;
  logic [`SOC_ADDR_W-1:0]  ram_ofs;
  soc_bus_pkg::slave_sel_e sel;
  logic                    err_ack_q;

  // window compare, wraps below the base so one unsigned test is enough
  assign clint_ofs = s_bus.addr - `SOC_CLINT_BASE;
  assign ram_ofs   = s_bus.addr - `SOC_RAM_BASE;

  always_comb begin
    if (clint_ofs < `SOC_CLINT_SIZE) begin
      sel = soc_bus_pkg::SEL_CLINT;
    end else if (ram_ofs < RAM_SIZE) begin
      sel = soc_bus_pkg::SEL_RAM;
    end else begin
      sel = soc_bus_pkg::SEL_NONE;
    end
  end

  // req only to the selected target, payload to both
  assign clint_bus.req   = s_bus.req && (sel == soc_bus_pkg::SEL_CLINT);
  assign clint_bus.op    = s_bus.op;
  assign clint_bus.addr  = s_bus.addr;
  assign clint_bus.wdata = s_bus.wdata;
  assign clint_bus.be    = s_bus.be;
  assign ram_bus.req     = s_bus.req && (sel == soc_bus_pkg::SEL_RAM);
  assign ram_bus.op      = s_bus.op;
  assign ram_bus.addr    = s_bus.addr;
  assign ram_bus.wdata   = s_bus.wdata;
  assign ram_bus.be      = s_bus.be;

  // error handshake, ack one cycle after req and drop one cycle after it
  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      err_ack_q <= 1'b0;
    end else begin
      err_ack_q <= s_bus.req && (sel == soc_bus_pkg::SEL_NONE);
    end
  end

  // response return path
  // keyed on ack so a payload change in phase 4 cannot reroute it
  assign s_bus.ack   = clint_bus.ack | ram_bus.ack | err_ack_q;
  assign s_bus.err   = err_ack_q | (clint_bus.ack & clint_bus.err) | (ram_bus.ack & ram_bus.err);
  assign s_bus.rdata = ({`SOC_DATA_W{clint_bus.ack}} & clint_bus.rdata)
                     | ({`SOC_DATA_W{ram_bus.ack}} & ram_bus.rdata);

endmodule

/* design/bus_arbiter.sv */
// ----------------------------------------
// round-robin arbiter between the core and the debug master
// grant is registered, then req and ack pass straight through
// ----------------------------------------
`include "soc_defs.svh"

module bus_arbiter (
  input  logic                   sys_clk_i,
  input  logic                   rst_n_i,
  input  logic                   core_req_i,
  input  soc_bus_pkg::bus_op_e   core_op_i,
  input  logic [`SOC_ADDR_W-1:0] core_addr_i,
  input  logic [`SOC_DATA_W-1:0] core_wdata_i,
  input  logic [`SOC_BE_W-1:0]   core_be_i,
  output logic                   core_ack_o,
  output logic [`SOC_DATA_W-1:0] core_rdata_o,
  output logic                   core_err_o,
  input  logic                   dbg_req_i,
  input  soc_bus_pkg::bus_op_e   dbg_op_i,
  input  logic [`SOC_ADDR_W-1:0] dbg_addr_i,
  input  logic [`SOC_DATA_W-1:0] dbg_wdata_i,
  input  logic [`SOC_BE_W-1:0]   dbg_be_i,
  output logic                   dbg_ack_o,
  output logic [`SOC_DATA_W-1:0] dbg_rdata_o,
  output logic                   dbg_err_o,
  soc_bus_if.master              m_bus
);

  soc_bus_pkg::arb_state_e  state_q, state_d;
  // grant_q doubles as the last master served
  soc_bus_pkg::master_sel_e grant_q, grant_d;
  logic                     gnt_req;
  logic                     core_sel;
  logic                     dbg_sel;

  assign gnt_req  = (grant_q == soc_bus_pkg::MST_CORE) ? core_req_i : dbg_req_i;
  assign core_sel = (state_q != soc_bus_pkg::IDLE) && (grant_q == soc_bus_pkg::MST_CORE);
  assign dbg_sel  = (state_q != soc_bus_pkg::IDLE) && (grant_q == soc_bus_pkg::MST_DEBUG);

  // ----------------------------------------
  // grant FSM
  // ----------------------------------------
  always_comb begin
    state_d = state_q;
    grant_d = grant_q;
    case (state_q)
      soc_bus_pkg::IDLE: begin
        if (core_req_i && dbg_req_i) begin
          // tie goes to whoever was not served last
          grant_d = (grant_q == soc_bus_pkg::MST_CORE) ? soc_bus_pkg::MST_DEBUG
                                                       : soc_bus_pkg::MST_CORE;
          state_d = soc_bus_pkg::BUSY;
        end else if (core_req_i) begin
          grant_d = soc_bus_pkg::MST_CORE;
          state_d = soc_bus_pkg::BUSY;
        end else if (dbg_req_i) begin
          grant_d = soc_bus_pkg::MST_DEBUG;
          state_d = soc_bus_pkg::BUSY;
        end
      end
      soc_bus_pkg::BUSY: begin
        if (!gnt_req) begin
          state_d = m_bus.ack ? soc_bus_pkg::RELEASE : soc_bus_pkg::IDLE;
        end
      end
      soc_bus_pkg::RELEASE: begin
        // wait for the target to close phase 4
        if (!m_bus.ack) begin
          state_d = soc_bus_pkg::IDLE;
        end
      end
      default: state_d = soc_bus_pkg::IDLE;
    endcase
  end

  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= soc_bus_pkg::IDLE;
      grant_q <= soc_bus_pkg::MST_DEBUG;
    end else begin
      state_q <= state_d;
      grant_q <= grant_d;
    end
  end

  // forward the granted request
  assign m_bus.req   = (state_q == soc_bus_pkg::BUSY) && gnt_req;
  assign m_bus.op    = (grant_q == soc_bus_pkg::MST_CORE) ? core_op_i    : dbg_op_i;
  assign m_bus.addr  = (grant_q == soc_bus_pkg::MST_CORE) ? core_addr_i  : dbg_addr_i;
  assign m_bus.wdata = (grant_q == soc_bus_pkg::MST_CORE) ? core_wdata_i : dbg_wdata_i;
  assign m_bus.be    = (grant_q == soc_bus_pkg::MST_CORE) ? core_be_i    : dbg_be_i;

  // response only to the granted master
  assign core_ack_o   = core_sel && m_bus.ack;
  assign core_err_o   = core_sel && m_bus.err;
  assign core_rdata_o = core_sel ? m_bus.rdata : '0;
  assign dbg_ack_o    = dbg_sel && m_bus.ack;
  assign dbg_err_o    = dbg_sel && m_bus.err;
  assign dbg_rdata_o  = dbg_sel ? m_bus.rdata : '0;

endmodule

/* design/clint_timer.sv */
// ----------------------------------------
// CLINT with msip, mtimecmp and mtime for a single hart
// mtime counts on sys_clk, irq and ipi go straight to the core
// ----------------------------------------
`include "soc_defs.svh"

module clint_timer (
  input  logic     sys_clk_i,
  input  logic     rst_n_i,
  soc_bus_if.slave s_bus,
  output logic     timer_irq_o,
  output logic     ipi_o
);

  logic [`SOC_DATA_W-1:0]    mtime_q;
  logic [`SOC_DATA_W-1:0]    mtimecmp_q;
  logic                      msip_q;
  logic                      ack_q;
  logic [`SOC_DATA_W-1:0]    rdata_q;
  logic                      access;
  logic [15:0]               ofs;
  soc_clint_pkg::clint_reg_e reg_sel;

  // one access per handshake, on the first cycle req is seen
  assign access = s_bus.req && !ack_q;

  // ----------------------------------------
  // register decode
  // ----------------------------------------
  // 8-byte aligned offset inside the window
  assign ofs = {s_bus.addr[15:3], 3'b000};

  always_comb begin
    case (ofs)
      soc_clint_pkg::CLINT_MSIP_OFS:     reg_sel = soc_clint_pkg::REG_MSIP;
      soc_clint_pkg::CLINT_MTIMECMP_OFS: reg_sel = soc_clint_pkg::REG_MTIMECMP;
      soc_clint_pkg::CLINT_MTIME_OFS:    reg_sel = soc_clint_pkg::REG_MTIME;
      default:                           reg_sel = soc_clint_pkg::REG_NONE;
    endcase
  end

  // ----------------------------------------
  // timer and registers
  // ----------------------------------------
  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q      <= 1'b0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
    end else begin
      ack_q   <= s_bus.req;
      mtime_q <= mtime_q + 1'b1;
      if (access && (s_bus.op == soc_bus_pkg::BUS_WRITE)) begin
        case (reg_sel)
          soc_clint_pkg::REG_MSIP: begin
            if (s_bus.be[0]) begin
              msip_q <= s_bus.wdata[0];
            end
          end
          soc_clint_pkg::REG_MTIMECMP: begin
            for (int i = 0; i < `SOC_BE_W; i++) begin
              if (s_bus.be[i]) begin
                mtimecmp_q[i*8 +: 8] <= s_bus.wdata[i*8 +: 8];
              end
            end
          end
          // mtime is read-only
          default: ;
        endcase
      end
    end
  end

  // read data captured with the access
  always_ff @(posedge sys_clk_i) begin
    if (access) begin
      case (reg_sel)
        soc_clint_pkg::REG_MSIP:     rdata_q <= {{(`SOC_DATA_W-1){1'b0}}, msip_q};
        soc_clint_pkg::REG_MTIMECMP: rdata_q <= mtimecmp_q;
        soc_clint_pkg::REG_MTIME:    rdata_q <= mtime_q;
        default:                     rdata_q <= '0;
      endcase
    end
  end

  assign s_bus.ack   = ack_q;
  assign s_bus.rdata = rdata_q;
  assign s_bus.err   = 1'b0;

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

/* design/scratch_ram.sv */
// ----------------------------------------
// scratch RAM in place of DRAM, 64-bit words with byte enables
// answers one cycle after req like the CLINT
// ----------------------------------------
`include "soc_defs.svh"

module scratch_ram (
  input  logic     sys_clk_i,
  input  logic     rst_n_i,
  soc_bus_if.slave s_bus
);

  localparam int BYTE_W = $clog2(`SOC_BE_W);
  localparam int IDX_W  = $clog2(`SOC_RAM_WORDS);

  logic [`SOC_DATA_W-1:0] mem [`SOC_RAM_WORDS];
  logic [IDX_W-1:0]       idx;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic                   ack_q;
  logic                   access;

  // word index above the byte offset
  assign idx    = s_bus.addr[BYTE_W +: IDX_W];
  assign access = s_bus.req && !ack_q;

  always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= s_bus.req;
    end
  end

  // storage, written bytes only
  always_ff @(posedge sys_clk_i) begin
    if (access) begin
      if (s_bus.op == soc_bus_pkg::BUS_WRITE) begin
        for (int i = 0; i < `SOC_BE_W; i++) begin
          if (s_bus.be[i]) begin
            mem[idx][i*8 +: 8] <= s_bus.wdata[i*8 +: 8];
          end
        end
      end
      rdata_q <= mem[idx];
    end
  end

  assign s_bus.ack   = ack_q;
  assign s_bus.rdata = rdata_q;
  assign s_bus.err   = 1'b0;

endmodule

/* design/soc_bus_if.sv */
// ----------------------------------------
// four-phase req/ack system bus
// master drives the request side, slave answers with ack, rdata and err
// ----------------------------------------
`include "soc_defs.svh"

interface soc_bus_if;

  // request side, stable while req is high
  logic                   req;
  soc_bus_pkg::bus_op_e   op;
  logic [`SOC_ADDR_W-1:0] addr;
  logic [`SOC_DATA_W-1:0] wdata;
  logic [`SOC_BE_W-1:0]   be;

  // response side, valid while ack is high
  logic                   ack;
  logic [`SOC_DATA_W-1:0] rdata;
  logic                   err;

  modport master (output req, op, addr, wdata, be, input ack, rdata, err);
  modport slave (input req, op, addr, wdata, be, output ack, rdata, err);

endinterface

/* design/soc_bus_pkg.sv */
// ----------------------------------------
// types shared by the system bus, the arbiter and the address decoder
// ----------------------------------------
package soc_bus_pkg;

  // access direction
  typedef enum logic {
    BUS_READ  = 1'b0,
    BUS_WRITE = 1'b1
  } bus_op_e;

  // target picked by the address decoder
  typedef enum logic [1:0] {
    SEL_CLINT = 2'd0,
    SEL_RAM   = 2'd1,
    SEL_NONE  = 2'd2
  } slave_sel_e;

  // bus masters
  typedef enum logic {
    MST_CORE  = 1'b0,
    MST_DEBUG = 1'b1
  } master_sel_e;

  // arbiter FSM
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    BUSY    = 2'd1,
    RELEASE = 2'd2
  } arb_state_e;

endpackage

/* design/soc_clint_pkg.sv */
// ----------------------------------------
// CLINT register map, offsets relative to the CLINT base
// ----------------------------------------
package soc_clint_pkg;

  typedef enum logic [1:0] {
    REG_MSIP     = 2'd0,
    REG_MTIMECMP = 2'd1,
    REG_MTIME    = 2'd2,
    REG_NONE     = 2'd3
  } clint_reg_e;

  // single hart, so one msip and one mtimecmp
  localparam logic [15:0] CLINT_MSIP_OFS     = 16'h0000;
  localparam logic [15:0] CLINT_MTIMECMP_OFS = 16'h4000;
  localparam logic [15:0] CLINT_MTIME_OFS    = 16'hBFF8;

endpackage

/* design/soc_top.sv */
// ----------------------------------------
// SoC interconnect top, core and debug masters share one bus
// to the CLINT and the scratch RAM
// ----------------------------------------
`include "soc_defs.svh"

module soc_top (
  input  logic                   sys_clk_i,
  input  logic                   rst_n_i,
  input  logic                   core_req_i,
  input  soc_bus_pkg::bus_op_e   core_op_i,
  input  logic [`SOC_ADDR_W-1:0] core_addr_i,
  input  logic [`SOC_DATA_W-1:0] core_wdata_i,
  input  logic [`SOC_BE_W-1:0]   core_be_i,
  output logic                   core_ack_o,
  output logic [`SOC_DATA_W-1:0] core_rdata_o,
  output logic                   core_err_o,
  input  logic                   dbg_req_i,
  input  soc_bus_pkg::bus_op_e   dbg_op_i,
  input  logic [`SOC_ADDR_W-1:0] dbg_addr_i,
  input  logic [`SOC_DATA_W-1:0] dbg_wdata_i,
  input  logic [`SOC_BE_W-1:0]   dbg_be_i,
  output logic                   dbg_ack_o,
  output logic [`SOC_DATA_W-1:0] dbg_rdata_o,
  output logic                   dbg_err_o,
  output logic                   timer_irq_o,
  output logic                   ipi_o
);

  soc_bus_if arb_bus ();
  soc_bus_if clint_bus ();
  soc_bus_if ram_bus ();

  // ----------------------------------------
  // decode stage
  // ----------------------------------------
  bus_arbiter i_bus_arbiter (
    .sys_clk_i    ( sys_clk_i    ),
    .rst_n_i      ( rst_n_i      ),
    .core_req_i   ( core_req_i   ),
    .core_op_i    ( core_op_i    ),
    .core_addr_i  ( core_addr_i  ),
    .core_wdata_i ( core_wdata_i ),
    .core_be_i    ( core_be_i    ),
    .core_ack_o   ( core_ack_o   ),
    .core_rdata_o ( core_rdata_o ),
    .core_err_o   ( core_err_o   ),
    .dbg_req_i    ( dbg_req_i    ),
    .dbg_op_i     ( dbg_op_i     ),
    .dbg_addr_i   ( dbg_addr_i   ),
    .dbg_wdata_i  ( dbg_wdata_i  ),
    .dbg_be_i     ( dbg_be_i     ),
    .dbg_ack_o    ( dbg_ack_o    ),
    .dbg_rdata_o  ( dbg_rdata_o  ),
    .dbg_err_o    ( dbg_err_o    ),
    .m_bus        ( arb_bus      )
  );

  addr_decoder i_addr_decoder (
    .s_bus     ( arb_bus   ),
    .clint_bus ( clint_bus ),
    .ram_bus   ( ram_bus   ),
    .sys_clk_i ( sys_clk_i ),
    .rst_n_i   ( rst_n_i   )
  );

  // ----------------------------------------
  // execute stage
  // ----------------------------------------
  clint_timer i_clint_timer (
    .sys_clk_i   ( sys_clk_i   ),
    .rst_n_i     ( rst_n_i     ),
    .s_bus       ( clint_bus   ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  scratch_ram i_scratch_ram (
    .sys_clk_i ( sys_clk_i ),
    .rst_n_i   ( rst_n_i   ),
    .s_bus     ( ram_bus   )
  );

endmodule

/* include/soc_defs.svh */
// ----------------------------------------
// widths, memory map and RAM depth of the SoC bus
// include wherever a width or an address window is needed
// ----------------------------------------
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

// bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_BE_W   8

// scratch RAM standing in for DRAM, 8-byte words
`define SOC_RAM_BASE  32'h8000_0000
`define SOC_RAM_WORDS 256

// CLINT window of 64 KiB
`define SOC_CLINT_BASE 32'h0200_0000
`define SOC_CLINT_SIZE 32'h0001_0000

`endif

/* list.f */
+incdir+include
design/soc_bus_pkg.sv
design/soc_clint_pkg.sv
design/soc_bus_if.sv
design/bus_arbiter.sv
design/addr_decoder.sv
design/clint_timer.sv
design/scratch_ram.sv
design/soc_top.sv
verification/soc_assert.sv
verification/soc_tb.sv

/* verification/soc_assert.sv */
// ----------------------------------------
// four-phase handshake checks, bound into the
// arbiter and the address decoder by the testbench
// ----------------------------------------
module soc_assert (
  input logic clk_i,
  input logic rst_n_i,
  input logic excl_a_i,
  input logic excl_b_i,
  input logic req_i,
  input logic ack_i
);

  // ----------------------------------------
  // handshake properties
  // ----------------------------------------
  // two acks to the masters, or two target reqs
  excl_ap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(excl_a_i && excl_b_i))
    else $error("two exclusive signals high in the same cycle");

  // phase 2 only follows phase 1
  ack_rise_ap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ack_i) |-> req_i)
    else $error("ack rose while req was low");

  // phase 4 only after phase 3
  ack_fall_ap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(ack_i) |-> !req_i)
    else $error("ack fell while req was still high");

endmodule

/* verification/soc_tb.sv */
// ----------------------------------------
// testbench for the SoC interconnect, random traffic from
// both masters checked against a RAM and CLINT model
// ----------------------------------------
`include "soc_defs.svh"

module soc_tb;

  localparam int SEED      = 82300;
  localparam int HALF_PER  = 20;
  localparam int DRIVE_DLY = 2;
  localparam int TIMEOUT   = 64;

  logic                   sys_clk;
  logic                   rst_n;
  logic                   core_req;
  soc_bus_pkg::bus_op_e   core_op;
  logic [`SOC_ADDR_W-1:0] core_addr;
  logic [`SOC_DATA_W-1:0] core_wdata;
  logic [`SOC_BE_W-1:0]   core_be;
  logic                   core_ack;
  logic [`SOC_DATA_W-1:0] core_rdata;
  logic                   core_err;
  logic                   dbg_req;
  soc_bus_pkg::bus_op_e   dbg_op;
  logic [`SOC_ADDR_W-1:0] dbg_addr;
  logic [`SOC_DATA_W-1:0] dbg_wdata;
  logic [`SOC_BE_W-1:0]   dbg_be;
  logic                   dbg_ack;
  logic [`SOC_DATA_W-1:0] dbg_rdata;
  logic                   dbg_err;
  logic                   timer_irq;
  logic                   ipi;

  // reference model state
  logic [`SOC_DATA_W-1:0] ram_model [int];
  logic                   msip_model;
  logic [`SOC_DATA_W-1:0] mtimecmp_model;

  soc_top UUT (
    .sys_clk_i    ( sys_clk    ),
    .rst_n_i      ( rst_n      ),
    .core_req_i   ( core_req   ),
    .core_op_i    ( core_op    ),
    .core_addr_i  ( core_addr  ),
    .core_wdata_i ( core_wdata ),
    .core_be_i    ( core_be    ),
    .core_ack_o   ( core_ack   ),
    .core_rdata_o ( core_rdata ),
    .core_err_o   ( core_err   ),
    .dbg_req_i    ( dbg_req    ),
    .dbg_op_i     ( dbg_op     ),
    .dbg_addr_i   ( dbg_addr   ),
    .dbg_wdata_i  ( dbg_wdata  ),
    .dbg_be_i     ( dbg_be     ),
    .dbg_ack_o    ( dbg_ack    ),
    .dbg_rdata_o  ( dbg_rdata  ),
    .dbg_err_o    ( dbg_err    ),
    .timer_irq_o  ( timer_irq  ),
    .ipi_o        ( ipi        )
  );

  bind bus_arbiter soc_assert i_arb_assert (
    .clk_i    ( sys_clk_i   ),
    .rst_n_i  ( rst_n_i     ),
    .excl_a_i ( core_ack_o  ),
    .excl_b_i ( dbg_ack_o   ),
    .req_i    ( m_bus.req   ),
    .ack_i    ( m_bus.ack   )
  );

  // target side handshake of the decoder
  bind addr_decoder soc_assert i_dec_assert (
    .clk_i    ( sys_clk_i                   ),
    .rst_n_i  ( rst_n_i                     ),
    .excl_a_i ( clint_bus.req               ),
    .excl_b_i ( ram_bus.req                 ),
    .req_i    ( clint_bus.req | ram_bus.req ),
    .ack_i    ( clint_bus.ack | ram_bus.ack )
  );

  always #HALF_PER sys_clk = ~sys_clk;

  // ----------------------------------------
  // reporting and model helpers
  // ----------------------------------------
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("mismatch at time %0t: %s got %h expected %h",
                              $time, name, got, exp));
    end
  endtask

  function automatic string port_name(input bit dbg, input string field);
    if (dbg) begin
      return {"dbg_", field};
    end
    return {"core_", field};
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old,
                                              input logic [63:0] data,
                                              input logic [7:0]  be);
    logic [63:0] res;
    res = old;
    for (int i = 0; i < 8; i++) begin
      if (be[i]) begin
        res[i*8 +: 8] = data[i*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic bit random_mst();
    return $urandom_range(0, 1) == 1;
  endfunction

  function automatic logic ack_of(input bit dbg);
    return dbg ? dbg_ack : core_ack;
  endfunction

  // ----------------------------------------
  // one four-phase access on either master
  // ----------------------------------------
  task automatic bus_access(input bit dbg, input soc_bus_pkg::bus_op_e op,
                            input logic [31:0] addr, input logic [63:0] wdata,
                            input logic [7:0] be, output logic [63:0] rdata,
                            output logic err);
    int cycles;
    @(posedge sys_clk);
    #DRIVE_DLY;
    if (dbg) begin
      dbg_op    = op;
      dbg_addr  = addr;
      dbg_wdata = wdata;
      dbg_be    = be;
      dbg_req   = 1'b1;
    end else begin
      core_op    = op;
      core_addr  = addr;
      core_wdata = wdata;
      core_be    = be;
      core_req   = 1'b1;
    end
    // outputs are sampled at the falling edge
    cycles = 0;
    @(negedge sys_clk);
    while (!ack_of(dbg)) begin
      if (cycles == TIMEOUT) begin
        stop_on_error($sformatf("timeout: %s never rose", port_name(dbg, "ack_o")));
      end
      cycles++;
      @(negedge sys_clk);
    end
    rdata = dbg ? dbg_rdata : core_rdata;
    err   = dbg ? dbg_err : core_err;
    @(posedge sys_clk);
    #DRIVE_DLY;
    if (dbg) begin
      dbg_req = 1'b0;
    end else begin
      core_req = 1'b0;
    end
    cycles = 0;
    @(negedge sys_clk);
    while (ack_of(dbg)) begin
      if (cycles == TIMEOUT) begin
        stop_on_error($sformatf("timeout: %s never fell", port_name(dbg, "ack_o")));
      end
      cycles++;
      @(negedge sys_clk);
    end
  endtask

  task automatic store_word(input bit dbg, input int idx, input logic [63:0] data,
                            input logic [7:0] be);
    logic [63:0] rd;
    logic        err;
    bus_access(dbg, soc_bus_pkg::BUS_WRITE, `SOC_RAM_BASE + 32'(idx * 8), data, be, rd, err);
    compare_value(port_name(dbg, "err_o"), 64'(err), 64'd0);
    ram_model[idx] = merge_bytes(ram_model.exists(idx) ? ram_model[idx] : '0, data, be);
  endtask

  task automatic load_and_check(input bit dbg, input int idx);
    logic [63:0] rd;
    logic        err;
    bus_access(dbg, soc_bus_pkg::BUS_READ, `SOC_RAM_BASE + 32'(idx * 8), '0, '0, rd, err);
    compare_value(port_name(dbg, "err_o"), 64'(err), 64'd0);
    compare_value(port_name(dbg, "rdata_o"), rd, ram_model[idx]);
  endtask

  task automatic write_clint(input bit dbg, input logic [15:0] ofs,
                             input logic [63:0] data, input logic [7:0] be);
    logic [63:0] rd;
    logic        err;
    bus_access(dbg, soc_bus_pkg::BUS_WRITE, `SOC_CLINT_BASE + {16'h0, ofs}, data, be, rd, err);
    compare_value(port_name(dbg, "err_o"), 64'(err), 64'd0);
    if (ofs == soc_clint_pkg::CLINT_MSIP_OFS && be[0]) begin
      msip_model = data[0];
    end else if (ofs == soc_clint_pkg::CLINT_MTIMECMP_OFS) begin
      mtimecmp_model = merge_bytes(mtimecmp_model, data, be);
    end
  endtask

  task automatic read_clint(input bit dbg, input logic [15:0] ofs, output logic [63:0] rd);
    logic err;
    bus_access(dbg, soc_bus_pkg::BUS_READ, `SOC_CLINT_BASE + {16'h0, ofs}, '0, '0, rd, err);
    compare_value(port_name(dbg, "err_o"), 64'(err), 64'd0);
  endtask

  // ----------------------------------------
  // test sequences
  // ----------------------------------------
  task automatic random_ram_traffic();
    int written[$];
    int idx;
    // full words first so no byte stays unknown
    for (int n = 0; n < 16; n++) begin
      idx = $urandom_range(0, `SOC_RAM_WORDS - 1);
      store_word(random_mst(), idx, {$urandom(), $urandom()}, 8'hFF);
      written.push_back(idx);
    end
    for (int n = 0; n < 32; n++) begin
      idx = written[$urandom_range(0, written.size() - 1)];
      store_word(random_mst(), idx, {$urandom(), $urandom()}, 8'($urandom()));
    end
    foreach (written[i]) begin
      load_and_check(random_mst(), written[i]);
    end
  endtask

  task automatic clint_interrupts();
    logic [63:0] rd;
    logic [63:0] mt1;
    logic [63:0] mt2;
    // software interrupt
    write_clint(random_mst(), soc_clint_pkg::CLINT_MSIP_OFS, 64'd1, 8'h01);
    compare_value("ipi_o", 64'(ipi), 64'd1);
    read_clint(random_mst(), soc_clint_pkg::CLINT_MSIP_OFS, rd);
    compare_value("msip", rd, {63'd0, msip_model});
    write_clint(random_mst(), soc_clint_pkg::CLINT_MSIP_OFS, 64'd0, 8'hFF);
    compare_value("ipi_o", 64'(ipi), 64'd0);
    read_clint(random_mst(), soc_clint_pkg::CLINT_MSIP_OFS, rd);
    compare_value("msip", rd, {63'd0, msip_model});
    // timer compare
    read_clint(1'b0, soc_clint_pkg::CLINT_MTIME_OFS, mt1);
    read_clint(1'b0, soc_clint_pkg::CLINT_MTIME_OFS, mt2);
    compare_value("mtime increasing", 64'(mt2 > mt1), 64'd1);
    write_clint(random_mst(), soc_clint_pkg::CLINT_MTIMECMP_OFS,
                mt2 - 64'($urandom_range(0, 15)), 8'hFF);
    compare_value("timer_irq_o", 64'(timer_irq), 64'd1);
    read_clint(random_mst(), soc_clint_pkg::CLINT_MTIMECMP_OFS, rd);
    compare_value("mtimecmp", rd, mtimecmp_model);
    write_clint(random_mst(), soc_clint_pkg::CLINT_MTIMECMP_OFS, '1, 8'hFF);
    compare_value("timer_irq_o", 64'(timer_irq), 64'd0);
    // byte merge on mtimecmp, then back to all ones
    write_clint(random_mst(), soc_clint_pkg::CLINT_MTIMECMP_OFS,
                {$urandom(), $urandom()}, 8'($urandom()));
    read_clint(random_mst(), soc_clint_pkg::CLINT_MTIMECMP_OFS, rd);
    compare_value("mtimecmp", rd, mtimecmp_model);
    write_clint(random_mst(), soc_clint_pkg::CLINT_MTIMECMP_OFS, '1, 8'hFF);
    // a hole in the window reads zero
    read_clint(random_mst(), 16'h0100, rd);
    compare_value("clint hole", rd, 64'd0);
  endtask

  task automatic unmapped_access();
    logic [63:0]          rd;
    logic                 err;
    logic [31:0]          addr;
    soc_bus_pkg::bus_op_e op;
    bit                   dbg;
    for (int n = 0; n < 6; n++) begin
      addr = 32'h4000_0000 | ($urandom() & 32'h0FFF_FFF8);
      op   = $urandom_range(0, 1) == 1 ? soc_bus_pkg::BUS_WRITE : soc_bus_pkg::BUS_READ;
      dbg  = random_mst();
      bus_access(dbg, op, addr, {$urandom(), $urandom()}, 8'hFF, rd, err);
      compare_value(port_name(dbg, "err_o"), 64'(err), 64'd1);
      compare_value(port_name(dbg, "rdata_o"), rd, 64'd0);
    end
  endtask

  // each master stays in its own half of the RAM
  task automatic master_stream(input bit dbg, input int base);
    int idx;
    for (int n = 0; n < 8; n++) begin
      idx = base + $urandom_range(0, `SOC_RAM_WORDS / 2 - 1);
      store_word(dbg, idx, {$urandom(), $urandom()}, 8'hFF);
      store_word(dbg, idx, {$urandom(), $urandom()}, 8'($urandom()));
      load_and_check(dbg, idx);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    sys_clk        = 1'b0;
    rst_n          = 1'b0;
    core_req       = 1'b0;
    core_op        = soc_bus_pkg::BUS_READ;
    core_addr      = '0;
    core_wdata     = '0;
    core_be        = '0;
    dbg_req        = 1'b0;
    dbg_op         = soc_bus_pkg::BUS_READ;
    dbg_addr       = '0;
    dbg_wdata      = '0;
    dbg_be         = '0;
    msip_model     = 1'b0;
    mtimecmp_model = '1;
    repeat (4) @(posedge sys_clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    @(negedge sys_clk);
    compare_value("timer_irq_o", 64'(timer_irq), 64'd0);
    compare_value("ipi_o", 64'(ipi), 64'd0);
    compare_value("core_ack_o", 64'(core_ack), 64'd0);
    compare_value("dbg_ack_o", 64'(dbg_ack), 64'd0);

    random_ram_traffic();
    clint_interrupts();
    unmapped_access();
    // both masters at once, neither may starve
    fork
      master_stream(1'b0, 0);
      master_stream(1'b1, `SOC_RAM_WORDS / 2);
    join

    $display("Simulation PASSED");
    $finish;
  end

endmodule
